/* Bender.yml */
package:
  name: lc4_superscalar

sources:
  # RTL, packages first
  - files:
      - hdl/lc4_isa_pkg.sv
      - hdl/lc4_pipe_pkg.sv
      - hdl/lc4_decoder.sv
      - hdl/lc4_regfile_2w.sv
      - hdl/lc4_issue_ctrl.sv
      - hdl/lc4_bypass_net.sv
      - hdl/lc4_exec_lane.sv
      - hdl/lc4_superscalar_core.sv
  # testbench
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_lc4_checker.sv
      - tests/tb_lc4_top.sv

/* files.f */
hdl/lc4_isa_pkg.sv
hdl/lc4_pipe_pkg.sv
hdl/lc4_decoder.sv
hdl/lc4_regfile_2w.sv
hdl/lc4_issue_ctrl.sv
hdl/lc4_bypass_net.sv
hdl/lc4_exec_lane.sv
hdl/lc4_superscalar_core.sv
tests/tb_clock_gen.sv
tests/tb_lc4_checker.sv
tests/tb_lc4_top.sv

/* hdl/lc4_bypass_net.sv */
`timescale 1ns/10ps

module lc4_bypass_net (
  input  lc4_isa_pkg::reg_idx_t i_x_rs_a, i_x_rt_a, i_x_rs_b, i_x_rt_b,
  input  lc4_isa_pkg::word_t    i_rf_rs_a, i_rf_rt_a, i_rf_rs_b, i_rf_rt_b,
  input  logic                  i_m_we_a, i_m_we_b, i_w_we_a, i_w_we_b,
  input  lc4_isa_pkg::reg_idx_t i_m_rd_a, i_m_rd_b, i_w_rd_a, i_w_rd_b,
  input  lc4_isa_pkg::word_t    i_m_val_a, i_m_val_b, i_w_val_a, i_w_val_b,
  output lc4_isa_pkg::word_t    o_op1_a, o_op2_a, o_op1_b, o_op2_b
);

  // newest producer first: M.B, M.A, W.B, W.A
  function automatic lc4_isa_pkg::word_t pick(input lc4_isa_pkg::reg_idx_t sel,
                                              input lc4_isa_pkg::word_t rf_val);
    if (i_m_we_b && i_m_rd_b == sel) return i_m_val_b;
    if (i_m_we_a && i_m_rd_a == sel) return i_m_val_a;
    if (i_w_we_b && i_w_rd_b == sel) return i_w_val_b;
    if (i_w_we_a && i_w_rd_a == sel) return i_w_val_a;
    return rf_val;
  endfunction

  always_comb begin
    o_op1_a = pick(i_x_rs_a, i_rf_rs_a);
    o_op2_a = pick(i_x_rt_a, i_rf_rt_a);
    o_op1_b = pick(i_x_rs_b, i_rf_rs_b);
    o_op2_b = pick(i_x_rt_b, i_rf_rt_b);
  end

endmodule

/* hdl/lc4_decoder.sv */
`timescale 1ns/10ps

module lc4_decoder (
  input  lc4_isa_pkg::word_t    i_insn,
  output lc4_isa_pkg::reg_idx_t o_rs_sel, o_rt_sel, o_rd_sel,
  output logic                  o_rs_re, o_rt_re, o_rf_we,
  output logic                  o_is_load, o_is_store, o_use_imm,
  output lc4_isa_pkg::word_t    o_imm
);

  logic [3:0] opcode;
  logic [2:0] sub;
  logic       imm_form;

  // sign-extend the low bits of w
  function automatic lc4_isa_pkg::word_t sext(input lc4_isa_pkg::word_t w, input int bits);
    lc4_isa_pkg::word_t sh;
    sh = w << (16 - bits);
    return $signed(sh) >>> (16 - bits);
  endfunction

  assign opcode   = i_insn[lc4_isa_pkg::OP_LSB +: 4];
  assign sub      = i_insn[lc4_isa_pkg::SUB_LSB +: 3];
  assign imm_form = i_insn[lc4_isa_pkg::IMM_SEL];

  always_comb begin
    o_rs_sel   = i_insn[lc4_isa_pkg::RS_LSB +: 3];
    o_rt_sel   = i_insn[lc4_isa_pkg::RT_LSB +: 3];
    o_rd_sel   = i_insn[lc4_isa_pkg::RD_LSB +: 3];
    o_rs_re    = 1'b0;
    o_rt_re    = 1'b0;
    o_rf_we    = 1'b0;
    o_is_load  = 1'b0;
    o_is_store = 1'b0;
    o_use_imm  = 1'b0;
    o_imm      = sext(i_insn, lc4_isa_pkg::IMM5_W);
    case (opcode)
      lc4_isa_pkg::OP_ARITH: begin
        if (imm_form || sub == lc4_isa_pkg::SUB_ADD || sub == lc4_isa_pkg::SUB_SUB) begin
          o_rs_re   = 1'b1;
          o_rt_re   = !imm_form;
          o_rf_we   = 1'b1;
          o_use_imm = imm_form;
        end
      end
      lc4_isa_pkg::OP_LOGIC: begin
        if (imm_form || sub == lc4_isa_pkg::SUB_AND || sub == lc4_isa_pkg::SUB_OR ||
            sub == lc4_isa_pkg::SUB_XOR) begin
          o_rs_re   = 1'b1;
          o_rt_re   = !imm_form;
          o_rf_we   = 1'b1;
          o_use_imm = imm_form;
        end
      end
      lc4_isa_pkg::OP_LDR: begin
        o_rs_re   = 1'b1;
        o_rf_we   = 1'b1;
        o_is_load = 1'b1;
        o_use_imm = 1'b1;
        o_imm     = sext(i_insn, lc4_isa_pkg::IMM6_W);
      end
      lc4_isa_pkg::OP_STR: begin
        o_rs_re    = 1'b1;
        o_rt_re    = 1'b1;
        o_rt_sel   = i_insn[lc4_isa_pkg::RD_LSB +: 3]; // store data sits in the rd field
        o_is_store = 1'b1;
        o_use_imm  = 1'b1;
        o_imm      = sext(i_insn, lc4_isa_pkg::IMM6_W);
      end
      lc4_isa_pkg::OP_CONST: begin
        o_rf_we   = 1'b1;
        o_use_imm = 1'b1;
        o_imm     = sext(i_insn, lc4_isa_pkg::IMM9_W);
      end
      default: ; // everything else runs as a nop
    endcase
  end

endmodule

/* hdl/lc4_exec_lane.sv */
`timescale 1ns/10ps

module lc4_exec_lane (
  input  logic                  gwe,
  input  logic                  i_rst,
  input  logic                  i_iss_valid,
  input  lc4_isa_pkg::word_t    i_iss_pc, i_iss_insn, i_iss_imm,
  input  lc4_pipe_pkg::stall_t  i_iss_stall,
  input  lc4_isa_pkg::reg_idx_t i_iss_rs_sel, i_iss_rt_sel, i_iss_rd_sel,
  input  logic                  i_iss_rs_re, i_iss_rt_re, i_iss_rf_we,
  input  logic                  i_iss_is_load, i_iss_is_store, i_iss_use_imm,
  input  lc4_isa_pkg::word_t    i_op1, i_op2, i_dmem_rdata,
  output lc4_isa_pkg::reg_idx_t o_x_rs, o_x_rt, o_x_rd,
  output logic                  o_x_load,
  output logic                  o_m_we, o_m_mem, o_m_store,
  output lc4_isa_pkg::reg_idx_t o_m_rd,
  output lc4_isa_pkg::word_t    o_m_val, o_m_addr, o_m_wdata,
  output logic                  o_w_we,
  output lc4_isa_pkg::reg_idx_t o_w_rd,
  output lc4_isa_pkg::word_t    o_w_val,
  output lc4_pipe_pkg::stall_t  o_tr_stall,
  output lc4_isa_pkg::word_t    o_tr_pc, o_tr_insn, o_tr_rf_data,
  output logic                  o_tr_rf_we, o_tr_dmem_we,
  output lc4_isa_pkg::reg_idx_t o_tr_rf_wsel,
  output lc4_isa_pkg::word_t    o_tr_dmem_addr, o_tr_dmem_data
);

  logic x_we, x_load, x_store, x_rs_re, x_rt_re, x_use_imm;
  logic m_we, m_load, m_store, w_we, w_store;
  lc4_pipe_pkg::stall_t x_stall, m_stall, w_stall;
  lc4_isa_pkg::reg_idx_t x_rs, x_rt, x_rd, m_rd, w_rd;
  lc4_isa_pkg::word_t x_pc, x_insn, x_imm, m_pc, m_insn, m_res, m_wdata;
  lc4_isa_pkg::word_t w_pc, w_insn, w_val, w_addr, w_data;
  lc4_isa_pkg::word_t op_a, op_rt, op_b, alu_res;
  logic [2:0] sub;

  assign op_a  = x_rs_re ? i_op1 : '0; // unread operands stay quiet
  assign op_rt = x_rt_re ? i_op2 : '0;
  assign op_b  = x_use_imm ? x_imm : op_rt;
  assign sub   = x_insn[lc4_isa_pkg::SUB_LSB +: 3];

  always_comb begin
    case (x_insn[lc4_isa_pkg::OP_LSB +: 4])
      lc4_isa_pkg::OP_ARITH: begin
        if (!x_use_imm && sub == lc4_isa_pkg::SUB_SUB) alu_res = op_a - op_b;
        else                                         alu_res = op_a + op_b;
      end
      lc4_isa_pkg::OP_LOGIC: begin
        if (x_use_imm)                         alu_res = op_a & op_b;
        else if (sub == lc4_isa_pkg::SUB_OR)   alu_res = op_a | op_b;
        else if (sub == lc4_isa_pkg::SUB_XOR)  alu_res = op_a ^ op_b;
        else                                   alu_res = op_a & op_b;
      end
      lc4_isa_pkg::OP_CONST: alu_res = x_imm;
      default:               alu_res = op_a + op_b; // LDR/STR address
    endcase
  end

  always_ff @(posedge gwe) begin
    if (i_rst) begin
      {x_we, x_load, x_store} <= '0;
      {m_we, m_load, m_store} <= '0;
      {w_we, w_store}         <= '0;
      x_stall <= lc4_pipe_pkg::STALL_EMPTY;
      m_stall <= lc4_pipe_pkg::STALL_EMPTY;
      w_stall <= lc4_pipe_pkg::STALL_EMPTY;
    end else begin
      x_we    <= i_iss_valid && i_iss_rf_we; // bubbles carry no side effects
      x_load  <= i_iss_valid && i_iss_is_load;
      x_store <= i_iss_valid && i_iss_is_store;
      x_stall <= i_iss_stall;
      m_we    <= x_we;
      m_load  <= x_load;
      m_store <= x_store;
      m_stall <= x_stall;
      w_we    <= m_we;
      w_store <= m_store;
      w_stall <= m_stall;
    end
  end

  always_ff @(posedge gwe) begin
    x_pc      <= i_iss_pc;
    x_insn    <= i_iss_insn;
    x_imm     <= i_iss_imm;
    x_rs      <= i_iss_rs_sel;
    x_rt      <= i_iss_rt_sel;
    x_rd      <= i_iss_rd_sel;
    x_rs_re   <= i_iss_rs_re;
    x_rt_re   <= i_iss_rt_re;
    x_use_imm <= i_iss_use_imm;
    m_pc      <= x_pc;
    m_insn    <= x_insn;
    m_rd      <= x_rd;
    m_res     <= alu_res;
    m_wdata   <= op_rt;
    w_pc      <= m_pc;
    w_insn    <= m_insn;
    w_rd      <= m_rd;
    w_val     <= o_m_val;
    w_addr    <= o_m_mem ? m_res : '0;
    w_data    <= m_load ? i_dmem_rdata : (m_store ? m_wdata : '0);
  end

  assign o_x_rs    = x_rs;
  assign o_x_rt    = x_rt;
  assign o_x_rd    = x_rd;
  assign o_x_load  = x_load;
  assign o_m_we    = m_we;
  assign o_m_rd    = m_rd;
  assign o_m_val   = m_load ? i_dmem_rdata : m_res; // loads forward the memory word
  assign o_m_mem   = m_load || m_store;
  assign o_m_store = m_store;
  assign o_m_addr  = m_res;
  assign o_m_wdata = m_wdata;
  assign o_w_we    = w_we;
  assign o_w_rd    = w_rd;
  assign o_w_val   = w_val;

  assign o_tr_stall     = w_stall;
  assign o_tr_pc        = w_pc;
  assign o_tr_insn      = w_insn;
  assign o_tr_rf_we     = w_we;
  assign o_tr_rf_wsel   = w_rd;
  assign o_tr_rf_data   = w_val;
  assign o_tr_dmem_we   = w_store;
  assign o_tr_dmem_addr = w_addr;
  assign o_tr_dmem_data = w_data;

endmodule

/* hdl/lc4_isa_pkg.sv */
package lc4_isa_pkg;

  typedef logic [15:0] word_t;    // data or instruction word
  typedef logic [2:0]  reg_idx_t; // register index

  localparam int NUM_REGS = 8;

  // major opcodes, insn[15:12]
  localparam logic [3:0] OP_NOP   = 4'b0000;
  localparam logic [3:0] OP_ARITH = 4'b0001;
  localparam logic [3:0] OP_LOGIC = 4'b0101;
  localparam logic [3:0] OP_LDR   = 4'b0110;
  localparam logic [3:0] OP_STR   = 4'b0111;
  localparam logic [3:0] OP_CONST = 4'b1001;

  // sub-ops in insn[5:3], only meaningful when bit 5 is clear
  localparam logic [2:0] SUB_ADD = 3'b000;
  localparam logic [2:0] SUB_SUB = 3'b010;
  localparam logic [2:0] SUB_AND = 3'b000;
  localparam logic [2:0] SUB_OR  = 3'b010;
  localparam logic [2:0] SUB_XOR = 3'b011;

  // field positions
  localparam int OP_LSB  = 12;
  localparam int RD_LSB  = 9;  // rd, or rt of a store
  localparam int RS_LSB  = 6;
  localparam int RT_LSB  = 0;
  localparam int SUB_LSB = 3;
  localparam int IMM_SEL = 5;  // set in ARITH/LOGIC means immediate form
  localparam int IMM5_W  = 5;
  localparam int IMM6_W  = 6;
  localparam int IMM9_W  = 9;

endpackage

/* hdl/lc4_issue_ctrl.sv */
`timescale 1ns/10ps

module lc4_issue_ctrl (
  input  logic                  gwe,
  input  logic                  i_rst,
  input  lc4_isa_pkg::word_t    i_cur_insn_a, i_cur_insn_b,
  input  logic                  i_x_load_a, i_x_load_b,
  input  lc4_isa_pkg::reg_idx_t i_x_rd_a, i_x_rd_b,
  output lc4_isa_pkg::word_t    o_cur_pc,
  output logic                  o_iss_valid_a, o_iss_valid_b,
  output lc4_isa_pkg::word_t    o_iss_pc_a, o_iss_pc_b, o_iss_insn_a, o_iss_insn_b,
  output lc4_pipe_pkg::stall_t  o_iss_stall_a, o_iss_stall_b,
  output lc4_isa_pkg::reg_idx_t o_rs_sel_a, o_rt_sel_a, o_rd_sel_a,
  output lc4_isa_pkg::reg_idx_t o_rs_sel_b, o_rt_sel_b, o_rd_sel_b,
  output logic                  o_rs_re_a, o_rt_re_a, o_rf_we_a, o_is_load_a, o_is_store_a,
  output logic                  o_rs_re_b, o_rt_re_b, o_rf_we_b, o_is_load_b, o_is_store_b,
  output logic                  o_use_imm_a, o_use_imm_b,
  output lc4_isa_pkg::word_t    o_imm_a, o_imm_b
);

  lc4_isa_pkg::word_t pc, d_insn_a, d_insn_b;
  logic d_valid; // low until the first fetch pair lands in D
  logic ltu_a, ltu_b, dep_ab, mem_pair, switch_pair;

  function automatic logic reads(input logic re1, input lc4_isa_pkg::reg_idx_t s1,
                                 input logic re2, input lc4_isa_pkg::reg_idx_t s2,
                                 input lc4_isa_pkg::reg_idx_t rd);
    return (re1 && s1 == rd) || (re2 && s2 == rd);
  endfunction

  lc4_decoder dec_a (
    .i_insn(d_insn_a), .o_rs_sel(o_rs_sel_a), .o_rt_sel(o_rt_sel_a), .o_rd_sel(o_rd_sel_a),
    .o_rs_re(o_rs_re_a), .o_rt_re(o_rt_re_a), .o_rf_we(o_rf_we_a), .o_is_load(o_is_load_a),
    .o_is_store(o_is_store_a), .o_use_imm(o_use_imm_a), .o_imm(o_imm_a)
  );

  lc4_decoder dec_b (
    .i_insn(d_insn_b), .o_rs_sel(o_rs_sel_b), .o_rt_sel(o_rt_sel_b), .o_rd_sel(o_rd_sel_b),
    .o_rs_re(o_rs_re_b), .o_rt_re(o_rt_re_b), .o_rf_we(o_rf_we_b), .o_is_load(o_is_load_b),
    .o_is_store(o_is_store_b), .o_use_imm(o_use_imm_b), .o_imm(o_imm_b)
  );

  // nops in D decode with every enable low, so no hazard fires before d_valid
  assign ltu_a = (i_x_load_a && reads(o_rs_re_a, o_rs_sel_a, o_rt_re_a, o_rt_sel_a, i_x_rd_a)) ||
                 (i_x_load_b && reads(o_rs_re_a, o_rs_sel_a, o_rt_re_a, o_rt_sel_a, i_x_rd_b));
  assign ltu_b = (i_x_load_a && reads(o_rs_re_b, o_rs_sel_b, o_rt_re_b, o_rt_sel_b, i_x_rd_a)) ||
                 (i_x_load_b && reads(o_rs_re_b, o_rs_sel_b, o_rt_re_b, o_rt_sel_b, i_x_rd_b));
  assign dep_ab   = o_rf_we_a && reads(o_rs_re_b, o_rs_sel_b, o_rt_re_b, o_rt_sel_b, o_rd_sel_a);
  assign mem_pair = (o_is_load_a || o_is_store_a) && (o_is_load_b || o_is_store_b);
  assign switch_pair = !ltu_a && (dep_ab || mem_pair || ltu_b);

  // the D pair always sits at pc-2 and pc-1
  assign o_cur_pc      = pc;
  assign o_iss_pc_a    = pc - 16'd2;
  assign o_iss_pc_b    = pc - 16'd1;
  assign o_iss_insn_a  = d_insn_a;
  assign o_iss_insn_b  = d_insn_b;
  assign o_iss_valid_a = d_valid && !ltu_a;
  assign o_iss_valid_b = d_valid && !ltu_a && !switch_pair;

  always_comb begin
    if (!d_valid) begin
      o_iss_stall_a = lc4_pipe_pkg::STALL_EMPTY;
      o_iss_stall_b = lc4_pipe_pkg::STALL_EMPTY;
    end else begin
      o_iss_stall_a = ltu_a ? lc4_pipe_pkg::STALL_LTU : lc4_pipe_pkg::STALL_NONE;
      if (ltu_a || dep_ab || mem_pair) o_iss_stall_b = lc4_pipe_pkg::STALL_SUPER;
      else if (ltu_b)                  o_iss_stall_b = lc4_pipe_pkg::STALL_LTU;
      else                             o_iss_stall_b = lc4_pipe_pkg::STALL_NONE;
    end
  end

  always_ff @(posedge gwe) begin
    if (i_rst) begin
      pc       <= lc4_pipe_pkg::RESET_PC;
      d_valid  <= 1'b0;
      d_insn_a <= {lc4_isa_pkg::OP_NOP, 12'h000};
      d_insn_b <= {lc4_isa_pkg::OP_NOP, 12'h000};
    end else begin
      d_valid <= 1'b1;
      if (switch_pair) begin // pipe switch, B slides over to A
        d_insn_a <= d_insn_b;
        d_insn_b <= i_cur_insn_a;
        pc       <= pc + 16'd1;
      end else if (!ltu_a) begin
        d_insn_a <= i_cur_insn_a;
        d_insn_b <= i_cur_insn_b;
        pc       <= pc + 16'd2;
      end
    end
  end

endmodule

/* hdl/lc4_pipe_pkg.sv */
package lc4_pipe_pkg;

  typedef logic [1:0] stall_t;

  localparam stall_t STALL_NONE  = 2'd0;
  localparam stall_t STALL_SUPER = 2'd1; // second lane held back
  localparam stall_t STALL_EMPTY = 2'd2; // slot never filled since reset
  localparam stall_t STALL_LTU   = 2'd3;

  localparam lc4_isa_pkg::word_t RESET_PC = 16'h8200;

endpackage

/* hdl/lc4_regfile_2w.sv */
`timescale 1ns/10ps

module lc4_regfile_2w (
  input  logic                  gwe,
  input  logic                  i_rst,
  input  lc4_isa_pkg::reg_idx_t i_rs_a, i_rt_a, i_rs_b, i_rt_b,
  output lc4_isa_pkg::word_t    o_rs_data_a, o_rt_data_a, o_rs_data_b, o_rt_data_b,
  input  logic                  i_we_a, i_we_b,
  input  lc4_isa_pkg::reg_idx_t i_wsel_a, i_wsel_b,
  input  lc4_isa_pkg::word_t    i_wdata_a, i_wdata_b
);

  lc4_isa_pkg::word_t regs [lc4_isa_pkg::NUM_REGS];

  // lane b is younger, so its write shadows lane a
  function automatic lc4_isa_pkg::word_t rd_port(input lc4_isa_pkg::reg_idx_t sel);
    if (i_we_b && i_wsel_b == sel) return i_wdata_b;
    if (i_we_a && i_wsel_a == sel) return i_wdata_a;
    return regs[sel];
  endfunction

  always_comb begin
    o_rs_data_a = rd_port(i_rs_a);
    o_rt_data_a = rd_port(i_rt_a);
    o_rs_data_b = rd_port(i_rs_b);
    o_rt_data_b = rd_port(i_rt_b);
  end

  always_ff @(posedge gwe) begin
    if (i_rst) begin
      for (int i = 0; i < lc4_isa_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (i_we_a) regs[i_wsel_a] <= i_wdata_a;
      if (i_we_b) regs[i_wsel_b] <= i_wdata_b; // last assignment wins
    end
  end

endmodule

/* hdl/lc4_superscalar_core.sv */
`timescale 1ns/10ps

module lc4_superscalar_core (
  input  logic                  gwe,
  input  logic                  i_rst,
  output lc4_isa_pkg::word_t    o_cur_pc,
  input  lc4_isa_pkg::word_t    i_cur_insn_a, i_cur_insn_b,
  output lc4_isa_pkg::word_t    o_dmem_addr, o_dmem_towrite,
  output logic                  o_dmem_we,
  input  lc4_isa_pkg::word_t    i_cur_dmem_data,
  output lc4_pipe_pkg::stall_t  o_tr_stall_a, o_tr_stall_b,
  output lc4_isa_pkg::word_t    o_tr_pc_a, o_tr_pc_b, o_tr_insn_a, o_tr_insn_b,
  output logic                  o_tr_rf_we_a, o_tr_rf_we_b,
  output lc4_isa_pkg::reg_idx_t o_tr_rf_wsel_a, o_tr_rf_wsel_b,
  output lc4_isa_pkg::word_t    o_tr_rf_data_a, o_tr_rf_data_b,
  output logic                  o_tr_dmem_we_a, o_tr_dmem_we_b,
  output lc4_isa_pkg::word_t    o_tr_dmem_addr_a, o_tr_dmem_addr_b,
  output lc4_isa_pkg::word_t    o_tr_dmem_data_a, o_tr_dmem_data_b
);

  logic iss_valid_a, iss_valid_b, rs_re_a, rs_re_b, rt_re_a, rt_re_b, rf_we_a, rf_we_b;
  logic is_load_a, is_load_b, is_store_a, is_store_b, use_imm_a, use_imm_b;
  lc4_isa_pkg::word_t iss_pc_a, iss_pc_b, iss_insn_a, iss_insn_b, imm_a, imm_b;
  lc4_pipe_pkg::stall_t iss_stall_a, iss_stall_b;
  lc4_isa_pkg::reg_idx_t rs_sel_a, rs_sel_b, rt_sel_a, rt_sel_b, rd_sel_a, rd_sel_b;
  lc4_isa_pkg::reg_idx_t x_rs_a, x_rs_b, x_rt_a, x_rt_b, x_rd_a, x_rd_b;
  lc4_isa_pkg::reg_idx_t m_rd_a, m_rd_b, w_rd_a, w_rd_b;
  logic x_load_a, x_load_b, m_we_a, m_we_b, m_mem_a, m_mem_b, m_store_a, m_store_b;
  logic w_we_a, w_we_b;
  lc4_isa_pkg::word_t m_val_a, m_val_b, m_addr_a, m_addr_b, m_wdata_a, m_wdata_b;
  lc4_isa_pkg::word_t w_val_a, w_val_b, op1_a, op1_b, op2_a, op2_b;
  lc4_isa_pkg::word_t rf_rs_a, rf_rs_b, rf_rt_a, rf_rt_b;

  lc4_issue_ctrl issue (
    .gwe(gwe), .i_rst(i_rst), .i_cur_insn_a(i_cur_insn_a), .i_cur_insn_b(i_cur_insn_b),
    .i_x_load_a(x_load_a), .i_x_load_b(x_load_b), .i_x_rd_a(x_rd_a), .i_x_rd_b(x_rd_b),
    .o_cur_pc(o_cur_pc), .o_iss_valid_a(iss_valid_a), .o_iss_valid_b(iss_valid_b),
    .o_iss_pc_a(iss_pc_a), .o_iss_pc_b(iss_pc_b),
    .o_iss_insn_a(iss_insn_a), .o_iss_insn_b(iss_insn_b),
    .o_iss_stall_a(iss_stall_a), .o_iss_stall_b(iss_stall_b),
    .o_rs_sel_a(rs_sel_a), .o_rt_sel_a(rt_sel_a), .o_rd_sel_a(rd_sel_a),
    .o_rs_sel_b(rs_sel_b), .o_rt_sel_b(rt_sel_b), .o_rd_sel_b(rd_sel_b),
    .o_rs_re_a(rs_re_a), .o_rt_re_a(rt_re_a), .o_rf_we_a(rf_we_a),
    .o_is_load_a(is_load_a), .o_is_store_a(is_store_a),
    .o_rs_re_b(rs_re_b), .o_rt_re_b(rt_re_b), .o_rf_we_b(rf_we_b),
    .o_is_load_b(is_load_b), .o_is_store_b(is_store_b),
    .o_use_imm_a(use_imm_a), .o_use_imm_b(use_imm_b), .o_imm_a(imm_a), .o_imm_b(imm_b)
  );

  lc4_regfile_2w regfile (
    .gwe(gwe), .i_rst(i_rst),
    .i_rs_a(x_rs_a), .i_rt_a(x_rt_a), .i_rs_b(x_rs_b), .i_rt_b(x_rt_b),
    .o_rs_data_a(rf_rs_a), .o_rt_data_a(rf_rt_a), .o_rs_data_b(rf_rs_b), .o_rt_data_b(rf_rt_b),
    .i_we_a(w_we_a), .i_wsel_a(w_rd_a), .i_wdata_a(w_val_a),
    .i_we_b(w_we_b), .i_wsel_b(w_rd_b), .i_wdata_b(w_val_b)
  );

  lc4_bypass_net bypass (
    .i_x_rs_a(x_rs_a), .i_x_rt_a(x_rt_a), .i_x_rs_b(x_rs_b), .i_x_rt_b(x_rt_b),
    .i_rf_rs_a(rf_rs_a), .i_rf_rt_a(rf_rt_a), .i_rf_rs_b(rf_rs_b), .i_rf_rt_b(rf_rt_b),
    .i_m_we_a(m_we_a), .i_m_we_b(m_we_b), .i_w_we_a(w_we_a), .i_w_we_b(w_we_b),
    .i_m_rd_a(m_rd_a), .i_m_rd_b(m_rd_b), .i_w_rd_a(w_rd_a), .i_w_rd_b(w_rd_b),
    .i_m_val_a(m_val_a), .i_m_val_b(m_val_b), .i_w_val_a(w_val_a), .i_w_val_b(w_val_b),
    .o_op1_a(op1_a), .o_op2_a(op2_a), .o_op1_b(op1_b), .o_op2_b(op2_b)
  );

  lc4_exec_lane lane_a (
    .gwe(gwe), .i_rst(i_rst), .i_iss_valid(iss_valid_a), .i_iss_pc(iss_pc_a),
    .i_iss_insn(iss_insn_a), .i_iss_imm(imm_a), .i_iss_stall(iss_stall_a),
    .i_iss_rs_sel(rs_sel_a), .i_iss_rt_sel(rt_sel_a), .i_iss_rd_sel(rd_sel_a),
    .i_iss_rs_re(rs_re_a), .i_iss_rt_re(rt_re_a), .i_iss_rf_we(rf_we_a),
    .i_iss_is_load(is_load_a), .i_iss_is_store(is_store_a), .i_iss_use_imm(use_imm_a),
    .i_op1(op1_a), .i_op2(op2_a), .i_dmem_rdata(i_cur_dmem_data),
    .o_x_rs(x_rs_a), .o_x_rt(x_rt_a), .o_x_rd(x_rd_a), .o_x_load(x_load_a),
    .o_m_we(m_we_a), .o_m_mem(m_mem_a), .o_m_store(m_store_a), .o_m_rd(m_rd_a),
    .o_m_val(m_val_a), .o_m_addr(m_addr_a), .o_m_wdata(m_wdata_a),
    .o_w_we(w_we_a), .o_w_rd(w_rd_a), .o_w_val(w_val_a),
    .o_tr_stall(o_tr_stall_a), .o_tr_pc(o_tr_pc_a), .o_tr_insn(o_tr_insn_a),
    .o_tr_rf_data(o_tr_rf_data_a), .o_tr_rf_we(o_tr_rf_we_a), .o_tr_dmem_we(o_tr_dmem_we_a),
    .o_tr_rf_wsel(o_tr_rf_wsel_a), .o_tr_dmem_addr(o_tr_dmem_addr_a),
    .o_tr_dmem_data(o_tr_dmem_data_a)
  );

  lc4_exec_lane lane_b (
    .gwe(gwe), .i_rst(i_rst), .i_iss_valid(iss_valid_b), .i_iss_pc(iss_pc_b),
    .i_iss_insn(iss_insn_b), .i_iss_imm(imm_b), .i_iss_stall(iss_stall_b),
    .i_iss_rs_sel(rs_sel_b), .i_iss_rt_sel(rt_sel_b), .i_iss_rd_sel(rd_sel_b),
    .i_iss_rs_re(rs_re_b), .i_iss_rt_re(rt_re_b), .i_iss_rf_we(rf_we_b),
    .i_iss_is_load(is_load_b), .i_iss_is_store(is_store_b), .i_iss_use_imm(use_imm_b),
    .i_op1(op1_b), .i_op2(op2_b), .i_dmem_rdata(i_cur_dmem_data),
    .o_x_rs(x_rs_b), .o_x_rt(x_rt_b), .o_x_rd(x_rd_b), .o_x_load(x_load_b),
    .o_m_we(m_we_b), .o_m_mem(m_mem_b), .o_m_store(m_store_b), .o_m_rd(m_rd_b),
    .o_m_val(m_val_b), .o_m_addr(m_addr_b), .o_m_wdata(m_wdata_b),
    .o_w_we(w_we_b), .o_w_rd(w_rd_b), .o_w_val(w_val_b),
    .o_tr_stall(o_tr_stall_b), .o_tr_pc(o_tr_pc_b), .o_tr_insn(o_tr_insn_b),
    .o_tr_rf_data(o_tr_rf_data_b), .o_tr_rf_we(o_tr_rf_we_b), .o_tr_dmem_we(o_tr_dmem_we_b),
    .o_tr_rf_wsel(o_tr_rf_wsel_b), .o_tr_dmem_addr(o_tr_dmem_addr_b),
    .o_tr_dmem_data(o_tr_dmem_data_b)
  );

  // issue keeps memory ops apart, so at most one lane drives the port
  assign o_dmem_addr    = m_mem_a ? m_addr_a : (m_mem_b ? m_addr_b : '0);
  assign o_dmem_we      = m_store_a || m_store_b;
  assign o_dmem_towrite = m_store_a ? m_wdata_a : (m_store_b ? m_wdata_b : '0);

endmodule

/* tests/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
  output logic gwe,
  output logic o_rst
);

  localparam int HALF_PERIOD = 50; // ns, 100 ns clock
  localparam int RST_CYCLES  = 16;

  initial begin
    gwe   = 1'b0;
    o_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge gwe);
    #1 o_rst = 1'b0; // release just after an edge
  end

  always #HALF_PERIOD gwe = ~gwe;

endmodule

/* tests/tb_lc4_checker.sv */
`timescale 1ns/10ps

module tb_lc4_checker #(
  parameter int PROG_LEN = 200
) (
  input  logic                  gwe,
  input  logic                  i_rst,
  input  lc4_pipe_pkg::stall_t  i_stall_a, i_stall_b,
  input  lc4_isa_pkg::word_t    i_pc_a, i_pc_b, i_insn_a, i_insn_b,
  input  logic                  i_rf_we_a, i_rf_we_b, i_dmem_we_a, i_dmem_we_b,
  input  lc4_isa_pkg::reg_idx_t i_wsel_a, i_wsel_b,
  input  lc4_isa_pkg::word_t    i_rf_data_a, i_rf_data_b,
  input  lc4_isa_pkg::word_t    i_dmem_addr_a, i_dmem_addr_b, i_dmem_data_a, i_dmem_data_b,
  output logic                  o_done,
  output int                    o_fail_tests
);

  lc4_isa_pkg::word_t model_rf [8] = '{default: '0}; // reset clears the registers
  lc4_isa_pkg::word_t model_mem [lc4_isa_pkg::word_t];
  lc4_isa_pkg::word_t exp_pc = lc4_pipe_pkg::RESET_PC;
  lc4_isa_pkg::word_t cur_pc;
  int n_chk [1:5];
  int n_err [1:5];
  int retired = 0;
  logic any_retired = 1'b0;
  logic saw_ltu     = 1'b0;
  string test_name [1:5] = '{"retirement order", "register writes", "stores", "loads",
                             "stall codes"};

  initial begin
    o_done       = 1'b0;
    o_fail_tests = 0;
    for (int t = 1; t <= 5; t++) begin
      n_chk[t] = 0;
      n_err[t] = 0;
    end
  end

  task automatic log_error(input int t, input string msg);
    n_err[t]++;
    $display("[FAIL] %0d ns, pc %h: %s", $time, cur_pc, msg);
  endtask

  task automatic check_value(input int t, input lc4_isa_pkg::word_t got, exp, input string what);
    n_chk[t]++;
    if (got !== exp) log_error(t, $sformatf("%s is %h, expected %h", what, got, exp));
  endtask

  // data memory as the program sees it with stores over the initial image
  function automatic lc4_isa_pkg::word_t mem_value(input lc4_isa_pkg::word_t a);
    if (model_mem.exists(a)) return model_mem[a];
    return tb_lc4_top.fill_mem[a];
  endfunction

  // word that the memory port actually wrote at a
  function automatic lc4_isa_pkg::word_t written_word(input lc4_isa_pkg::word_t a);
    if (tb_lc4_top.dmem.exists(a)) return tb_lc4_top.dmem[a];
    return 'x;
  endfunction

  task automatic handle_slot(input lc4_pipe_pkg::stall_t stall,
                             input lc4_isa_pkg::word_t pc, insn,
                             input logic rf_we,
                             input lc4_isa_pkg::reg_idx_t wsel,
                             input lc4_isa_pkg::word_t rf_data,
                             input logic dmem_we,
                             input lc4_isa_pkg::word_t addr, data);
    lc4_isa_pkg::word_t prog, rs_v, rt_v, st_v, ea, res, imm5, imm6, imm9;
    logic [2:0] rd;
    logic exp_we, exp_ld, exp_st;
    if (retired >= PROG_LEN) return;
    cur_pc = pc;
    if (stall != lc4_pipe_pkg::STALL_NONE) begin
      n_chk[5]++;
      if (stall == lc4_pipe_pkg::STALL_LTU) saw_ltu = 1'b1;
      if (!any_retired && stall != lc4_pipe_pkg::STALL_EMPTY)
        log_error(5, $sformatf("stall code %0d before the first retirement", stall));
      else if (any_retired && stall != lc4_pipe_pkg::STALL_SUPER &&
               stall != lc4_pipe_pkg::STALL_LTU)
        log_error(5, $sformatf("stall code %0d on a bubble", stall));
      return;
    end
    any_retired = 1'b1;
    prog = tb_lc4_top.imem[exp_pc - lc4_pipe_pkg::RESET_PC];
    check_value(1, pc, exp_pc, "trace pc");
    check_value(1, insn, prog, "trace insn");
    if (exp_pc == lc4_pipe_pkg::RESET_PC + 16'd2) begin // preamble ADD waits on the LDR
      n_chk[5]++;
      if (!saw_ltu) log_error(5, "no load-to-use bubble ahead of the preamble ADD");
    end
    rd   = prog[11:9];
    rs_v = model_rf[prog[8:6]];
    rt_v = model_rf[prog[2:0]];
    st_v = model_rf[rd];                              // store data register
    imm5 = {{11{prog[4]}}, prog[4:0]};
    imm6 = {{10{prog[5]}}, prog[5:0]};
    imm9 = {{7{prog[8]}}, prog[8:0]};
    ea   = rs_v + imm6;
    exp_we = 1'b0;
    exp_ld = 1'b0;
    exp_st = 1'b0;
    res    = '0;
    case (prog[15:12])
      lc4_isa_pkg::OP_ARITH: begin
        exp_we = prog[5] || prog[4:3] == 2'b00 || prog[4:3] == 2'b10; // add, sub, add-imm
        res    = prog[5] ? rs_v + imm5 : (prog[4] ? rs_v - rt_v : rs_v + rt_v);
      end
      lc4_isa_pkg::OP_LOGIC: begin
        exp_we = prog[5] || prog[4:3] != 2'b01; // NOT is not in the subset
        if (prog[5])                 res = rs_v & imm5;
        else if (prog[4:3] == 2'b10) res = rs_v | rt_v;
        else if (prog[4:3] == 2'b11) res = rs_v ^ rt_v;
        else                         res = rs_v & rt_v;
      end
      lc4_isa_pkg::OP_LDR: begin
        exp_we = 1'b1;
        exp_ld = 1'b1;
        res    = mem_value(ea);
      end
      lc4_isa_pkg::OP_STR:   exp_st = 1'b1;
      lc4_isa_pkg::OP_CONST: begin
        exp_we = 1'b1;
        res    = imm9;
      end
      default: ;
    endcase
    check_value(2, rf_we, exp_we, "rf_we");
    if (exp_we) begin
      check_value(2, wsel, rd, "rf_wsel");
      check_value(2, rf_data, res, "rf_data");
    end
    check_value(3, dmem_we, exp_st, "dmem_we");
    if (exp_st) begin
      check_value(3, addr, ea, "store addr");
      check_value(3, data, st_v, "store data");
      check_value(3, written_word(ea), st_v, "memory word after the store");
    end
    if (exp_ld) begin
      check_value(4, addr, ea, "load addr");
      check_value(4, data, res, "load data");
    end
    if (exp_we) model_rf[rd] = res;
    if (exp_st) model_mem[ea] = st_v;
    exp_pc++;
    retired++;
  endtask

  task automatic report_totals();
    int passed = 0;
    int failed = 0;
    for (int t = 1; t <= 5; t++) begin
      if (n_err[t] == 0) passed++;
      else failed++;
      $display("test %0d, %s: %0d checks, %0d errors", t, test_name[t], n_chk[t], n_err[t]);
    end
    $display("totals: %0d tests ok, %0d tests with errors", passed, failed);
    o_fail_tests = failed;
    o_done       = 1'b1;
  endtask

  // trace registers are stable at the falling edge
  always @(negedge gwe) begin
    if (!i_rst && !o_done) begin
      // lane A holds the older slot
      handle_slot(i_stall_a, i_pc_a, i_insn_a, i_rf_we_a, i_wsel_a, i_rf_data_a,
                  i_dmem_we_a, i_dmem_addr_a, i_dmem_data_a);
      handle_slot(i_stall_b, i_pc_b, i_insn_b, i_rf_we_b, i_wsel_b, i_rf_data_b,
                  i_dmem_we_b, i_dmem_addr_b, i_dmem_data_b);
      if (retired >= PROG_LEN) report_totals();
    end
  end

endmodule

/* tests/tb_lc4_top.sv */
`timescale 1ns/10ps

module tb_lc4_top;

  localparam int PROG_LEN       = 200;
  localparam int SEED           = 90;
  localparam int TIMEOUT_CYCLES = 16 + 4 * PROG_LEN + 20;

  logic gwe, rst, dmem_we, chk_done;
  lc4_isa_pkg::word_t cur_pc, dmem_addr, dmem_towrite;
  lc4_isa_pkg::word_t cur_insn_a    = '0;
  lc4_isa_pkg::word_t cur_insn_b    = '0;
  lc4_isa_pkg::word_t cur_dmem_data = '0;
  lc4_pipe_pkg::stall_t tr_stall_a, tr_stall_b;
  lc4_isa_pkg::word_t tr_pc_a, tr_pc_b, tr_insn_a, tr_insn_b, tr_rf_data_a, tr_rf_data_b;
  lc4_isa_pkg::word_t tr_dmem_addr_a, tr_dmem_addr_b, tr_dmem_data_a, tr_dmem_data_b;
  logic tr_rf_we_a, tr_rf_we_b, tr_dmem_we_a, tr_dmem_we_b;
  lc4_isa_pkg::reg_idx_t tr_wsel_a, tr_wsel_b;
  int fail_tests;
  int cycle_cnt = 0;
  integer seed = SEED;

  lc4_isa_pkg::word_t imem [PROG_LEN];              // word i sits at RESET_PC + i
  lc4_isa_pkg::word_t fill_mem [65536];             // contents of never-written data words
  lc4_isa_pkg::word_t dmem [lc4_isa_pkg::word_t];   // words written by stores

  function automatic lc4_isa_pkg::word_t random_insn();
    int kind;
    lc4_isa_pkg::word_t bits;
    logic [2:0] lsub;
    kind = $unsigned($random(seed)) % 8;
    bits = $random(seed);
    lsub = bits[14] ? 3'b011 : (bits[13] ? 3'b010 : 3'b000); // and, or, xor
    case (kind)
      0: return {lc4_isa_pkg::OP_ARITH, bits[11:6], 3'b000, bits[2:0]}; // add
      1: return {lc4_isa_pkg::OP_ARITH, bits[11:6], 3'b010, bits[2:0]}; // sub
      2: return {lc4_isa_pkg::OP_ARITH, bits[11:6], 1'b1, bits[4:0]};
      3: return {lc4_isa_pkg::OP_LOGIC, bits[11:6], lsub, bits[2:0]};
      4: return {lc4_isa_pkg::OP_LOGIC, bits[11:6], 1'b1, bits[4:0]};
      5: return {lc4_isa_pkg::OP_CONST, bits[11:0]};
      6: return {lc4_isa_pkg::OP_LDR, bits[11:0]};
      default: return {lc4_isa_pkg::OP_STR, bits[11:0]};
    endcase
  endfunction

  function automatic lc4_isa_pkg::word_t fetch_word(input lc4_isa_pkg::word_t pc);
    lc4_isa_pkg::word_t idx;
    if ($isunknown(pc)) return '0;
    idx = pc - lc4_pipe_pkg::RESET_PC;
    if (idx < PROG_LEN) return imem[idx];
    return {lc4_isa_pkg::OP_NOP, 12'h000}; // past the program
  endfunction

  function automatic lc4_isa_pkg::word_t read_data(input lc4_isa_pkg::word_t addr);
    if ($isunknown(addr)) return '0;
    if (dmem.exists(addr)) return dmem[addr];
    return fill_mem[addr];
  endfunction

  task automatic build_memories();
    imem[0] = {lc4_isa_pkg::OP_CONST, 3'd1, 9'd5};               // CONST r1,5
    imem[1] = {lc4_isa_pkg::OP_LDR, 3'd2, 3'd1, 6'd0};           // LDR r2,r1,0
    imem[2] = {lc4_isa_pkg::OP_ARITH, 3'd3, 3'd2, 3'b000, 3'd2}; // ADD r3,r2,r2
    imem[3] = {lc4_isa_pkg::OP_STR, 3'd3, 3'd1, 6'd1};           // STR r3,r1,1
    for (int i = 4; i < PROG_LEN; i++) begin
      imem[i] = random_insn();
    end
    for (int a = 0; a < 65536; a++) begin
      fill_mem[a] = $random(seed);
    end
  endtask

  tb_clock_gen clk_gen (.gwe(gwe), .o_rst(rst));

  lc4_superscalar_core dut0 (
    .gwe(gwe), .i_rst(rst), .o_cur_pc(cur_pc),
    .i_cur_insn_a(cur_insn_a), .i_cur_insn_b(cur_insn_b),
    .o_dmem_addr(dmem_addr), .o_dmem_towrite(dmem_towrite), .o_dmem_we(dmem_we),
    .i_cur_dmem_data(cur_dmem_data),
    .o_tr_stall_a(tr_stall_a), .o_tr_stall_b(tr_stall_b),
    .o_tr_pc_a(tr_pc_a), .o_tr_pc_b(tr_pc_b), .o_tr_insn_a(tr_insn_a), .o_tr_insn_b(tr_insn_b),
    .o_tr_rf_we_a(tr_rf_we_a), .o_tr_rf_we_b(tr_rf_we_b),
    .o_tr_rf_wsel_a(tr_wsel_a), .o_tr_rf_wsel_b(tr_wsel_b),
    .o_tr_rf_data_a(tr_rf_data_a), .o_tr_rf_data_b(tr_rf_data_b),
    .o_tr_dmem_we_a(tr_dmem_we_a), .o_tr_dmem_we_b(tr_dmem_we_b),
    .o_tr_dmem_addr_a(tr_dmem_addr_a), .o_tr_dmem_addr_b(tr_dmem_addr_b),
    .o_tr_dmem_data_a(tr_dmem_data_a), .o_tr_dmem_data_b(tr_dmem_data_b)
  );

  tb_lc4_checker #(.PROG_LEN(PROG_LEN)) trace_chk (
    .gwe(gwe), .i_rst(rst),
    .i_stall_a(tr_stall_a), .i_stall_b(tr_stall_b),
    .i_pc_a(tr_pc_a), .i_pc_b(tr_pc_b), .i_insn_a(tr_insn_a), .i_insn_b(tr_insn_b),
    .i_rf_we_a(tr_rf_we_a), .i_rf_we_b(tr_rf_we_b),
    .i_dmem_we_a(tr_dmem_we_a), .i_dmem_we_b(tr_dmem_we_b),
    .i_wsel_a(tr_wsel_a), .i_wsel_b(tr_wsel_b),
    .i_rf_data_a(tr_rf_data_a), .i_rf_data_b(tr_rf_data_b),
    .i_dmem_addr_a(tr_dmem_addr_a), .i_dmem_addr_b(tr_dmem_addr_b),
    .i_dmem_data_a(tr_dmem_data_a), .i_dmem_data_b(tr_dmem_data_b),
    .o_done(chk_done), .o_fail_tests(fail_tests)
  );

  // stores land on the edge and fetch and load data 1 ns after it
  always @(posedge gwe) begin
    if (dmem_we === 1'b1) dmem[dmem_addr] = dmem_towrite;
    #1;
    cur_insn_a    = fetch_word(cur_pc);
    cur_insn_b    = fetch_word(cur_pc + 16'd1);
    cur_dmem_data = read_data(dmem_addr);
  end

  initial begin
    build_memories();
    while (chk_done !== 1'b1 && cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge gwe);
      cycle_cnt++;
    end
    if (chk_done === 1'b1 && fail_tests == 0) begin
      $display("All tests passed");
    end else begin
      if (chk_done !== 1'b1) $display("timeout: not all instructions retired");
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
